// File: hdl/wb_bus_pkg.sv
package wb_bus_pkg;

   // Byte address and data word
   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;

   // One enable per byte lane of the data word
   typedef logic [3:0] wb_sel_t;

   // Registered feedback cycle type and burst extension
   typedef logic [2:0] wb_cti_t;
   typedef logic [1:0] wb_bte_t;

   // One-hot slave select, bit positions come from the SoC map
   typedef logic [2:0] slave_sel_t;

endpackage

// File: hdl/soc_map_pkg.sv
package soc_map_pkg;

   // Bit positions in slave_sel_t
   localparam int unsigned slave_ram  = 0;
   localparam int unsigned slave_regs = 1;
   localparam int unsigned slave_ext  = 2;

   // Register block sits where adr[31:24] matches
   localparam int unsigned addr_match_width = 8;
   localparam logic [addr_match_width-1:0] regs_match = 8'h91;

   // RAM window, all address bits from here upward are zero
   localparam int unsigned ram_addr_width = 12;

   // Word offsets inside the register block
   localparam int unsigned reg_scratch0 = 0;
   localparam int unsigned reg_scratch1 = 1;
   localparam int unsigned reg_scratch2 = 2;
   localparam int unsigned reg_scratch3 = 3;
   localparam int unsigned reg_id       = 4;

   // Value returned by reg_id
   localparam logic [31:0] soc_id = 32'h50c0_d8b1;

endpackage

// File: hdl/dbus_arbiter.sv
`timescale 1ns/100ps

module dbus_arbiter #(
   parameter int unsigned ram_addr_width_p = soc_map_pkg::ram_addr_width,
   parameter int unsigned watchdog_width_p = 6
) (
   input  logic                   wb_clk,
   input  logic                   wb_rst,

   // Master 0, CPU data port
   input  wb_bus_pkg::wb_adr_t    wbm0_adr_i,
   input  wb_bus_pkg::wb_dat_t    wbm0_dat_i,
   input  wb_bus_pkg::wb_sel_t    wbm0_sel_i,
   input  logic                   wbm0_we_i,
   input  logic                   wbm0_cyc_i,
   input  logic                   wbm0_stb_i,
   input  wb_bus_pkg::wb_cti_t    wbm0_cti_i,
   input  wb_bus_pkg::wb_bte_t    wbm0_bte_i,
   output wb_bus_pkg::wb_dat_t    wbm0_dat_o,
   output logic                   wbm0_ack_o,
   output logic                   wbm0_err_o,
   output logic                   wbm0_rty_o,

   // Master 1, debug port
   input  wb_bus_pkg::wb_adr_t    wbm1_adr_i,
   input  wb_bus_pkg::wb_dat_t    wbm1_dat_i,
   input  wb_bus_pkg::wb_sel_t    wbm1_sel_i,
   input  logic                   wbm1_we_i,
   input  logic                   wbm1_cyc_i,
   input  logic                   wbm1_stb_i,
   input  wb_bus_pkg::wb_cti_t    wbm1_cti_i,
   input  wb_bus_pkg::wb_bte_t    wbm1_bte_i,
   output wb_bus_pkg::wb_dat_t    wbm1_dat_o,
   output logic                   wbm1_ack_o,
   output logic                   wbm1_err_o,
   output logic                   wbm1_rty_o,

   // Shared slave request
   output wb_bus_pkg::wb_adr_t    wbs_adr_o,
   output wb_bus_pkg::wb_dat_t    wbs_dat_o,
   output wb_bus_pkg::wb_sel_t    wbs_sel_o,
   output logic                   wbs_we_o,
   output wb_bus_pkg::wb_cti_t    wbs_cti_o,
   output wb_bus_pkg::wb_bte_t    wbs_bte_o,
   output wb_bus_pkg::slave_sel_t wbs_cyc_o,
   output wb_bus_pkg::slave_sel_t wbs_stb_o,

   // Slave responses
   input  wb_bus_pkg::wb_dat_t    wbs_ram_dat_i,
   input  wb_bus_pkg::wb_dat_t    wbs_regs_dat_i,
   input  wb_bus_pkg::wb_dat_t    wbs_ext_dat_i,
   input  wb_bus_pkg::slave_sel_t wbs_ack_i,
   input  wb_bus_pkg::slave_sel_t wbs_err_i,
   input  wb_bus_pkg::slave_sel_t wbs_rty_i
);

   localparam int unsigned match_lsb = 32 - soc_map_pkg::addr_match_width;

   logic                          m0_own;
   logic                          m1_own;
   logic                          m_cyc;
   logic                          m_stb;
   wb_bus_pkg::slave_sel_t        sel_d;
   wb_bus_pkg::slave_sel_t        sel_r;
   wb_bus_pkg::wb_dat_t           s_dat;
   logic                          s_ack;
   logic                          s_err;
   logic                          s_rty;
   logic                          wd_err;
   logic                          stb_r;
   logic                          m1_own_r;
   logic                          stb_edge;
   logic [watchdog_width_p-1:0]   wd_timer;

   // Debug port wins whenever its cyc is up
   assign m1_own = wbm1_cyc_i;
   assign m0_own = wbm0_cyc_i & ~wbm1_cyc_i;

   assign wbs_adr_o = m1_own ? wbm1_adr_i : wbm0_adr_i;
   assign wbs_dat_o = m1_own ? wbm1_dat_i : wbm0_dat_i;
   assign wbs_sel_o = m1_own ? wbm1_sel_i : wbm0_sel_i;
   assign wbs_we_o  = m1_own ? wbm1_we_i  : wbm0_we_i;
   assign wbs_cti_o = m1_own ? wbm1_cti_i : wbm0_cti_i;
   assign wbs_bte_o = m1_own ? wbm1_bte_i : wbm0_bte_i;
   assign m_cyc     = m1_own ? wbm1_cyc_i : wbm0_cyc_i;
   assign m_stb     = m1_own ? wbm1_stb_i : wbm0_stb_i;

   // Address decode, RAM first, then registers, else the byte bus
   always_comb begin
      sel_d = '0;
      if (~|wbs_adr_o[31:ram_addr_width_p])
         sel_d[soc_map_pkg::slave_ram] = 1'b1;
      else if (wbs_adr_o[31:match_lsb] == soc_map_pkg::regs_match)
         sel_d[soc_map_pkg::slave_regs] = 1'b1;
      else
         sel_d[soc_map_pkg::slave_ext] = 1'b1;
   end

   // Registered select keeps the default slave out of any comb loop
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         sel_r <= '0;
         sel_r[soc_map_pkg::slave_ext] <= 1'b1;
      end else begin
         sel_r <= sel_d;
      end
   end

   // Strobe only where the stale select agrees with the live decode,
   // so a slave never acts on an address meant for another one
   assign wbs_cyc_o = {3{m_cyc}} & sel_r;
   assign wbs_stb_o = {3{m_stb}} & sel_r & sel_d;

   always_comb begin
      s_dat = wbs_ext_dat_i;
      if (sel_r[soc_map_pkg::slave_ram])
         s_dat = wbs_ram_dat_i;
      else if (sel_r[soc_map_pkg::slave_regs])
         s_dat = wbs_regs_dat_i;
   end

   assign s_ack = |(wbs_ack_i & sel_r);
   assign s_err = |(wbs_err_i & sel_r) | wd_err;
   assign s_rty = |(wbs_rty_i & sel_r);

   // Watchdog restarts on a new strobe or a change of owner
   assign stb_edge = m_stb & (~stb_r | (m1_own != m1_own_r));

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         stb_r    <= 1'b0;
         m1_own_r <= 1'b0;
         wd_timer <= '0;
      end else begin
         stb_r    <= m_stb;
         m1_own_r <= m1_own;
         // Any slave response ends the access
         if (!m_stb || s_ack || (|(wbs_err_i & sel_r)) || s_rty)
            wd_timer <= '0;
         else if (stb_edge)
            wd_timer <= {{(watchdog_width_p-1){1'b0}}, 1'b1};
         else if (&wd_timer)
            wd_timer <= '0;
         else if (|wd_timer)
            wd_timer <= wd_timer + 1'b1;
      end
   end

   // Timeout error, held off if a slave answers in the same cycle
   assign wd_err = (&wd_timer) & m_stb & ~s_ack & ~s_rty;

   // Responses reach the owning master only
   assign wbm0_dat_o = m0_own ? s_dat : '0;
   assign wbm0_ack_o = s_ack & m0_own;
   assign wbm0_err_o = s_err & m0_own;
   assign wbm0_rty_o = s_rty & m0_own;

   assign wbm1_dat_o = m1_own ? s_dat : '0;
   assign wbm1_ack_o = s_ack & m1_own;
   assign wbm1_err_o = s_err & m1_own;
   assign wbm1_rty_o = s_rty & m1_own;

endmodule

// File: hdl/wb_ram.sv
`timescale 1ns/100ps

module wb_ram #(
   parameter int unsigned ram_addr_width_p = soc_map_pkg::ram_addr_width
) (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  wb_bus_pkg::wb_adr_t adr_i,
   input  wb_bus_pkg::wb_dat_t dat_i,
   input  wb_bus_pkg::wb_sel_t sel_i,
   input  logic                we_i,
   input  logic                cyc_i,
   input  logic                stb_i,
   output wb_bus_pkg::wb_dat_t dat_o,
   output logic                ack_o
);

   localparam int unsigned words = 2 ** (ram_addr_width_p - 2);

   wb_bus_pkg::wb_dat_t             mem [words];
   logic [ram_addr_width_p-3:0]     word_idx;
   logic                            req;

   // Word index, byte offset dropped
   assign word_idx = adr_i[ram_addr_width_p-1:2];

   // One request per strobe, none while the ack is still up
   assign req = cyc_i & stb_i & ~ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= req;
   end

   // Array and read data carry no reset
   always_ff @(posedge wb_clk) begin
      if (req) begin
         if (we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
               if (sel_i[lane])
                  mem[word_idx][lane*8 +: 8] <= dat_i[lane*8 +: 8];
            end
         end
         dat_o <= mem[word_idx];
      end
   end

endmodule

// File: hdl/wb_ctrl_regs.sv
`timescale 1ns/100ps

module wb_ctrl_regs (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  wb_bus_pkg::wb_adr_t adr_i,
   input  wb_bus_pkg::wb_dat_t dat_i,
   input  wb_bus_pkg::wb_sel_t sel_i,
   input  logic                we_i,
   input  logic                cyc_i,
   input  logic                stb_i,
   output wb_bus_pkg::wb_dat_t dat_o,
   output logic                ack_o,
   output logic                err_o
);

   // Word offset within the 16 MiB register window
   localparam int unsigned off_width = 30 - soc_map_pkg::addr_match_width;

   localparam int unsigned scratch_off [4] = '{
      soc_map_pkg::reg_scratch0,
      soc_map_pkg::reg_scratch1,
      soc_map_pkg::reg_scratch2,
      soc_map_pkg::reg_scratch3
   };

   wb_bus_pkg::wb_dat_t   scratch [4];
   wb_bus_pkg::wb_dat_t   rd_dat;
   logic [off_width-1:0]  off;
   logic                  req;
   logic                  illegal;

   assign off = adr_i[off_width+1:2];
   assign req = cyc_i & stb_i & ~ack_o & ~err_o;

   // ID is read only, nothing lives above it
   assign illegal = (off > soc_map_pkg::reg_id) |
                    (we_i & (off == soc_map_pkg::reg_id));

   always_comb begin
      rd_dat = '0;
      if (off == soc_map_pkg::reg_id)
         rd_dat = soc_map_pkg::soc_id;
      for (int i = 0; i < 4; i++) begin
         if (off == scratch_off[i])
            rd_dat = scratch[i];
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end else begin
         ack_o <= req & ~illegal;
         err_o <= req & illegal;
         if (req & we_i & ~illegal) begin
            for (int i = 0; i < 4; i++) begin
               for (int lane = 0; lane < 4; lane++) begin
                  if ((off == scratch_off[i]) && sel_i[lane])
                     scratch[i][lane*8 +: 8] <= dat_i[lane*8 +: 8];
               end
            end
         end
      end
   end

   // Read data goes out with the ack
   always_ff @(posedge wb_clk) begin
      if (req)
         dat_o <= rd_dat;
   end

endmodule

// File: hdl/dbus_top.sv
`timescale 1ns/100ps

module dbus_top #(
   parameter int unsigned ram_addr_width_p = soc_map_pkg::ram_addr_width,
   parameter int unsigned watchdog_width_p = 6
) (
   input  logic                wb_clk,
   input  logic                wb_rst,

   input  wb_bus_pkg::wb_adr_t wbm0_adr_i,
   input  wb_bus_pkg::wb_dat_t wbm0_dat_i,
   input  wb_bus_pkg::wb_sel_t wbm0_sel_i,
   input  logic                wbm0_we_i,
   input  logic                wbm0_cyc_i,
   input  logic                wbm0_stb_i,
   input  wb_bus_pkg::wb_cti_t wbm0_cti_i,
   input  wb_bus_pkg::wb_bte_t wbm0_bte_i,
   output wb_bus_pkg::wb_dat_t wbm0_dat_o,
   output logic                wbm0_ack_o,
   output logic                wbm0_err_o,
   output logic                wbm0_rty_o,

   input  wb_bus_pkg::wb_adr_t wbm1_adr_i,
   input  wb_bus_pkg::wb_dat_t wbm1_dat_i,
   input  wb_bus_pkg::wb_sel_t wbm1_sel_i,
   input  logic                wbm1_we_i,
   input  logic                wbm1_cyc_i,
   input  logic                wbm1_stb_i,
   input  wb_bus_pkg::wb_cti_t wbm1_cti_i,
   input  wb_bus_pkg::wb_bte_t wbm1_bte_i,
   output wb_bus_pkg::wb_dat_t wbm1_dat_o,
   output logic                wbm1_ack_o,
   output logic                wbm1_err_o,
   output logic                wbm1_rty_o,

   // Byte bus, default slave outside the chip
   output wb_bus_pkg::wb_adr_t ext_adr_o,
   output wb_bus_pkg::wb_dat_t ext_dat_o,
   output wb_bus_pkg::wb_sel_t ext_sel_o,
   output logic                ext_we_o,
   output logic                ext_cyc_o,
   output logic                ext_stb_o,
   output wb_bus_pkg::wb_cti_t ext_cti_o,
   output wb_bus_pkg::wb_bte_t ext_bte_o,
   input  wb_bus_pkg::wb_dat_t ext_dat_i,
   input  logic                ext_ack_i,
   input  logic                ext_err_i,
   input  logic                ext_rty_i
);

   wb_bus_pkg::wb_dat_t    s_dat;
   wb_bus_pkg::slave_sel_t s_cyc;
   wb_bus_pkg::slave_sel_t s_stb;
   wb_bus_pkg::slave_sel_t s_ack;
   wb_bus_pkg::slave_sel_t s_err;
   wb_bus_pkg::slave_sel_t s_rty;
   wb_bus_pkg::wb_dat_t    ram_dat;
   wb_bus_pkg::wb_dat_t    regs_dat;

   // Shared request fans out to the byte bus as is
   assign ext_dat_o = s_dat;
   assign ext_cyc_o = s_cyc[soc_map_pkg::slave_ext];
   assign ext_stb_o = s_stb[soc_map_pkg::slave_ext];

   // RAM never errs, neither internal slave retries
   assign s_err[soc_map_pkg::slave_ram]  = 1'b0;
   assign s_rty[soc_map_pkg::slave_ram]  = 1'b0;
   assign s_rty[soc_map_pkg::slave_regs] = 1'b0;
   assign s_ack[soc_map_pkg::slave_ext]  = ext_ack_i;
   assign s_err[soc_map_pkg::slave_ext]  = ext_err_i;
   assign s_rty[soc_map_pkg::slave_ext]  = ext_rty_i;

   dbus_arbiter #(
      .ram_addr_width_p (ram_addr_width_p),
      .watchdog_width_p (watchdog_width_p)
   ) dbus_arbiter_i (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .wbm0_adr_i     (wbm0_adr_i),
      .wbm0_dat_i     (wbm0_dat_i),
      .wbm0_sel_i     (wbm0_sel_i),
      .wbm0_we_i      (wbm0_we_i),
      .wbm0_cyc_i     (wbm0_cyc_i),
      .wbm0_stb_i     (wbm0_stb_i),
      .wbm0_cti_i     (wbm0_cti_i),
      .wbm0_bte_i     (wbm0_bte_i),
      .wbm0_dat_o     (wbm0_dat_o),
      .wbm0_ack_o     (wbm0_ack_o),
      .wbm0_err_o     (wbm0_err_o),
      .wbm0_rty_o     (wbm0_rty_o),
      .wbm1_adr_i     (wbm1_adr_i),
      .wbm1_dat_i     (wbm1_dat_i),
      .wbm1_sel_i     (wbm1_sel_i),
      .wbm1_we_i      (wbm1_we_i),
      .wbm1_cyc_i     (wbm1_cyc_i),
      .wbm1_stb_i     (wbm1_stb_i),
      .wbm1_cti_i     (wbm1_cti_i),
      .wbm1_bte_i     (wbm1_bte_i),
      .wbm1_dat_o     (wbm1_dat_o),
      .wbm1_ack_o     (wbm1_ack_o),
      .wbm1_err_o     (wbm1_err_o),
      .wbm1_rty_o     (wbm1_rty_o),
      .wbs_adr_o      (ext_adr_o),
      .wbs_dat_o      (s_dat),
      .wbs_sel_o      (ext_sel_o),
      .wbs_we_o       (ext_we_o),
      .wbs_cti_o      (ext_cti_o),
      .wbs_bte_o      (ext_bte_o),
      .wbs_cyc_o      (s_cyc),
      .wbs_stb_o      (s_stb),
      .wbs_ram_dat_i  (ram_dat),
      .wbs_regs_dat_i (regs_dat),
      .wbs_ext_dat_i  (ext_dat_i),
      .wbs_ack_i      (s_ack),
      .wbs_err_i      (s_err),
      .wbs_rty_i      (s_rty)
   );

   wb_ram #(
      .ram_addr_width_p (ram_addr_width_p)
   ) wb_ram_i (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .adr_i  (ext_adr_o),
      .dat_i  (s_dat),
      .sel_i  (ext_sel_o),
      .we_i   (ext_we_o),
      .cyc_i  (s_cyc[soc_map_pkg::slave_ram]),
      .stb_i  (s_stb[soc_map_pkg::slave_ram]),
      .dat_o  (ram_dat),
      .ack_o  (s_ack[soc_map_pkg::slave_ram])
   );

   wb_ctrl_regs wb_ctrl_regs_i (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .adr_i  (ext_adr_o),
      .dat_i  (s_dat),
      .sel_i  (ext_sel_o),
      .we_i   (ext_we_o),
      .cyc_i  (s_cyc[soc_map_pkg::slave_regs]),
      .stb_i  (s_stb[soc_map_pkg::slave_regs]),
      .dat_o  (regs_dat),
      .ack_o  (s_ack[soc_map_pkg::slave_regs]),
      .err_o  (s_err[soc_map_pkg::slave_regs])
   );

endmodule

// File: bench/dbus_arbiter_checker.sv
`timescale 1ns/100ps

module dbus_arbiter_checker (
   input logic                   wb_clk,
   input logic                   wb_rst,
   input logic                   wbm0_cyc_i,
   input logic                   wbm1_cyc_i,
   input logic                   wbm0_ack_o,
   input logic                   wbm0_err_o,
   input logic                   wbm1_ack_o,
   input logic                   wbm1_err_o,
   input wb_bus_pkg::slave_sel_t wbs_stb_o
);

   // One slave strobed at most
   stb_onehot: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0(wbs_stb_o))
      else $error("more than one slave strobe high");

   // Acks only reach the owner
   m0_ack_owner: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wbm1_cyc_i |-> !wbm0_ack_o)
      else $error("master 0 acked while the debug port owns the bus");

   m1_ack_owner: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wbm0_cyc_i && !wbm1_cyc_i) |-> !wbm1_ack_o)
      else $error("debug port acked while master 0 owns the bus");

   m0_ack_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(wbm0_ack_o && wbm0_err_o))
      else $error("master 0 sees ack and err together");

   m1_ack_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(wbm1_ack_o && wbm1_err_o))
      else $error("debug port sees ack and err together");

endmodule

bind dbus_arbiter dbus_arbiter_checker dbus_arbiter_checker_i (
   .wb_clk     (wb_clk),
   .wb_rst     (wb_rst),
   .wbm0_cyc_i (wbm0_cyc_i),
   .wbm1_cyc_i (wbm1_cyc_i),
   .wbm0_ack_o (wbm0_ack_o),
   .wbm0_err_o (wbm0_err_o),
   .wbm1_ack_o (wbm1_ack_o),
   .wbm1_err_o (wbm1_err_o),
   .wbs_stb_o  (wbs_stb_o)
);

// File: bench/dbus_tb.sv
`timescale 1ns/100ps

module dbus_tb;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 10;
   localparam int wd_width     = 6;
   localparam int access_bound = 100;
   localparam int wd_bound     = 2 ** wd_width + 4;
   localparam int ram_words    = 16;
   localparam int ram_depth    = 1024;
   // Accesses of the ram, regs, ext, priority and watchdog tests
   localparam int test_accesses  = 3 * ram_words + 16 + 4 + 2 + 2;
   localparam int timeout_cycles = reset_cycles + test_accesses * (access_bound + 2);

   typedef enum logic [1:0] {resp_none, resp_ack, resp_err, resp_rty} resp_t;

   logic                   wb_clk;
   logic                   wb_rst;
   wb_bus_pkg::wb_adr_t    wbm0_adr_i, wbm1_adr_i, ext_adr_o;
   wb_bus_pkg::wb_dat_t    wbm0_dat_i, wbm1_dat_i, wbm0_dat_o, wbm1_dat_o;
   wb_bus_pkg::wb_dat_t    ext_dat_o, ext_dat_i;
   wb_bus_pkg::wb_sel_t    wbm0_sel_i, wbm1_sel_i, ext_sel_o;
   wb_bus_pkg::wb_cti_t    wbm0_cti_i, wbm1_cti_i, ext_cti_o;
   wb_bus_pkg::wb_bte_t    wbm0_bte_i, wbm1_bte_i, ext_bte_o;
   logic                   wbm0_we_i, wbm0_cyc_i, wbm0_stb_i;
   logic                   wbm0_ack_o, wbm0_err_o, wbm0_rty_o;
   logic                   wbm1_we_i, wbm1_cyc_i, wbm1_stb_i;
   logic                   wbm1_ack_o, wbm1_err_o, wbm1_rty_o;
   logic                   ext_we_o, ext_cyc_o, ext_stb_o;
   logic                   ext_ack_i, ext_err_i, ext_rty_i;

   string                  test_name = "reset";
   int                     errors = 0;
   int unsigned            ram_idx [ram_words];
   wb_bus_pkg::wb_dat_t    ram_model [ram_depth];

   // External slave wait cycles, answer kind, read contents and last request seen
   int                     ext_delay = 0;
   resp_t                  ext_mode = resp_ack;
   wb_bus_pkg::wb_dat_t    ext_mem [64];
   wb_bus_pkg::wb_adr_t    ext_last_adr;
   wb_bus_pkg::wb_dat_t    ext_last_dat;
   wb_bus_pkg::wb_sel_t    ext_last_sel;
   logic                   ext_last_we;
   wb_bus_pkg::wb_cti_t    ext_last_cti;
   wb_bus_pkg::wb_bte_t    ext_last_bte;

   dbus_top dbus_top_i (.*);

   initial begin : clock_gen
      wb_clk = 1'b0;
      forever #(clk_period / 2) wb_clk = ~wb_clk;
   end

   // Samples the request at the rising edge and answers at the falling edge
   initial begin : ext_slave_model
      int                  waited;
      resp_t               next;
      wb_bus_pkg::wb_dat_t rd_next;
      ext_ack_i = 1'b0;
      ext_err_i = 1'b0;
      ext_rty_i = 1'b0;
      ext_dat_i = '0;
      waited = 0;
      rd_next = '0;
      forever begin
         @(posedge wb_clk);
         next = resp_none;
         if (!(ext_cyc_o && ext_stb_o) || ext_ack_i || ext_err_i || ext_rty_i) begin
            waited = 0;
         end else begin
            waited++;
            if (waited > ext_delay && ext_mode != resp_none) begin
               next = ext_mode;
               ext_last_adr = ext_adr_o;
               ext_last_dat = ext_dat_o;
               ext_last_sel = ext_sel_o;
               ext_last_we = ext_we_o;
               ext_last_cti = ext_cti_o;
               ext_last_bte = ext_bte_o;
               rd_next = ext_mem[ext_adr_o[7:2]];
            end
         end
         @(negedge wb_clk);
         ext_ack_i = (next == resp_ack);
         ext_err_i = (next == resp_err);
         ext_rty_i = (next == resp_rty);
         ext_dat_i = (next == resp_none) ? '0 : rd_next;
      end
   end

   task automatic abort_run(string why);
      errors++;
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic value_mismatch(string what, string exp, string act);
      abort_run($sformatf("** Error: test %s, %s expected %s, actual %s",
                          test_name, what, exp, act));
   endtask

   task automatic check_dat(wb_bus_pkg::wb_dat_t exp, wb_bus_pkg::wb_dat_t act);
      if (exp !== act)
         value_mismatch("data", $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_adr(wb_bus_pkg::wb_adr_t exp, wb_bus_pkg::wb_adr_t act);
      if (exp !== act)
         value_mismatch("address", $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_resp(resp_t exp, resp_t act);
      if (exp != act)
         value_mismatch("response", exp.name(), act.name());
   endtask

   task automatic check_ctl(wb_bus_pkg::wb_sel_t exp_sel, logic exp_we,
                            wb_bus_pkg::wb_sel_t act_sel, logic act_we);
      if (exp_sel !== act_sel || exp_we !== act_we)
         value_mismatch("sel/we", $sformatf("%h/%b", exp_sel, exp_we),
                        $sformatf("%h/%b", act_sel, act_we));
   endtask

   task automatic check_burst(wb_bus_pkg::wb_cti_t exp_cti, wb_bus_pkg::wb_bte_t exp_bte,
                              wb_bus_pkg::wb_cti_t act_cti, wb_bus_pkg::wb_bte_t act_bte);
      if (exp_cti !== act_cti || exp_bte !== act_bte)
         value_mismatch("cti/bte", $sformatf("%h/%h", exp_cti, exp_bte),
                        $sformatf("%h/%h", act_cti, act_bte));
   endtask

   // Reference byte lane update for RAM and scratch contents
   function automatic wb_bus_pkg::wb_dat_t merge_lanes(wb_bus_pkg::wb_dat_t old,
         wb_bus_pkg::wb_dat_t nw, wb_bus_pkg::wb_sel_t sel);
      wb_bus_pkg::wb_dat_t res;
      res = old;
      for (int l = 0; l < 4; l++) begin
         if (sel[l])
            res[l*8 +: 8] = nw[l*8 +: 8];
      end
      return res;
   endfunction

   function automatic wb_bus_pkg::wb_adr_t reg_adr(int unsigned off);
      return {soc_map_pkg::regs_match, 24'(off * 4)};
   endfunction

   task automatic drive_master(int m, logic active, logic we, wb_bus_pkg::wb_adr_t adr,
                               wb_bus_pkg::wb_dat_t dat, wb_bus_pkg::wb_sel_t sel);
      if (m == 0) begin
         wbm0_cyc_i = active;
         wbm0_stb_i = active;
         wbm0_we_i = we;
         wbm0_adr_i = adr;
         wbm0_dat_i = dat;
         wbm0_sel_i = sel;
      end else begin
         wbm1_cyc_i = active;
         wbm1_stb_i = active;
         wbm1_we_i = we;
         wbm1_adr_i = adr;
         wbm1_dat_i = dat;
         wbm1_sel_i = sel;
      end
   endtask

   function automatic resp_t sample_resp(int m);
      if ((m == 0) ? wbm0_ack_o : wbm1_ack_o)
         return resp_ack;
      if ((m == 0) ? wbm0_err_o : wbm1_err_o)
         return resp_err;
      if ((m == 0) ? wbm0_rty_o : wbm1_rty_o)
         return resp_rty;
      return resp_none;
   endfunction

   // Classic cycle with the request held until a response or the bound runs out
   task automatic bus_cycle(int m, logic we, wb_bus_pkg::wb_adr_t adr,
                            wb_bus_pkg::wb_dat_t wdat, wb_bus_pkg::wb_sel_t sel, int bound,
                            output wb_bus_pkg::wb_dat_t rdat, output resp_t resp);
      int n;
      n = 0;
      resp = resp_none;
      rdat = '0;
      @(negedge wb_clk);
      drive_master(m, 1'b1, we, adr, wdat, sel);
      while (resp == resp_none && n < bound) begin
         @(posedge wb_clk);
         n++;
         resp = sample_resp(m);
         rdat = (m == 0) ? wbm0_dat_o : wbm1_dat_o;
      end
      @(negedge wb_clk);
      drive_master(m, 1'b0, 1'b0, '0, '0, '0);
   endtask

   task automatic wb_write(int m, wb_bus_pkg::wb_adr_t adr, wb_bus_pkg::wb_dat_t dat,
                           wb_bus_pkg::wb_sel_t sel, output resp_t resp);
      wb_bus_pkg::wb_dat_t unused_dat;
      bus_cycle(m, 1'b1, adr, dat, sel, access_bound, unused_dat, resp);
   endtask

   task automatic wb_read(int m, wb_bus_pkg::wb_adr_t adr, int bound,
                          output wb_bus_pkg::wb_dat_t dat, output resp_t resp);
      bus_cycle(m, 1'b0, adr, '0, 4'hf, bound, dat, resp);
   endtask

   task automatic test_ram();
      wb_bus_pkg::wb_dat_t wdat;
      wb_bus_pkg::wb_dat_t rdat;
      wb_bus_pkg::wb_sel_t sel;
      resp_t               resp;
      test_name = "ram";
      // Full words first so every checked location is known
      for (int i = 0; i < ram_words; i++) begin
         ram_idx[i] = $urandom % ram_depth;
         wdat = $urandom;
         wb_write(i % 2, wb_bus_pkg::wb_adr_t'(ram_idx[i] * 4), wdat, 4'hf, resp);
         check_resp(resp_ack, resp);
         ram_model[ram_idx[i]] = wdat;
      end
      for (int i = 0; i < ram_words; i++) begin
         wdat = $urandom;
         sel = wb_bus_pkg::wb_sel_t'($urandom);
         wb_write((i + 1) % 2, wb_bus_pkg::wb_adr_t'(ram_idx[i] * 4), wdat, sel, resp);
         check_resp(resp_ack, resp);
         ram_model[ram_idx[i]] = merge_lanes(ram_model[ram_idx[i]], wdat, sel);
      end
      for (int i = 0; i < ram_words; i++) begin
         wb_read(i % 2, wb_bus_pkg::wb_adr_t'(ram_idx[i] * 4), access_bound, rdat, resp);
         check_resp(resp_ack, resp);
         check_dat(ram_model[ram_idx[i]], rdat);
      end
   endtask

   task automatic test_regs();
      wb_bus_pkg::wb_dat_t wdat;
      wb_bus_pkg::wb_dat_t rdat;
      wb_bus_pkg::wb_sel_t sel;
      wb_bus_pkg::wb_dat_t model [4];
      resp_t               resp;
      test_name = "regs";
      for (int i = 0; i < 4; i++) begin
         model[i] = '0;
         wb_read(i % 2, reg_adr(soc_map_pkg::reg_scratch0 + i), access_bound, rdat, resp);
         check_resp(resp_ack, resp);
         check_dat(32'h0, rdat);
      end
      for (int i = 0; i < 4; i++) begin
         wdat = $urandom;
         sel = wb_bus_pkg::wb_sel_t'($urandom);
         wb_write(i % 2, reg_adr(soc_map_pkg::reg_scratch0 + i), wdat, sel, resp);
         check_resp(resp_ack, resp);
         model[i] = merge_lanes(model[i], wdat, sel);
      end
      for (int i = 0; i < 4; i++) begin
         wb_read((i + 1) % 2, reg_adr(soc_map_pkg::reg_scratch0 + i), access_bound, rdat, resp);
         check_resp(resp_ack, resp);
         check_dat(model[i], rdat);
      end
      wb_read(0, reg_adr(soc_map_pkg::reg_id), access_bound, rdat, resp);
      check_resp(resp_ack, resp);
      check_dat(soc_map_pkg::soc_id, rdat);
      // Read-only ID and the hole above it
      wb_write(1, reg_adr(soc_map_pkg::reg_id), ~soc_map_pkg::soc_id, 4'hf, resp);
      check_resp(resp_err, resp);
      wb_read(0, reg_adr(soc_map_pkg::reg_id + 1), access_bound, rdat, resp);
      check_resp(resp_err, resp);
      wb_read(1, reg_adr(soc_map_pkg::reg_id), access_bound, rdat, resp);
      check_resp(resp_ack, resp);
      check_dat(soc_map_pkg::soc_id, rdat);
   endtask

   task automatic test_ext();
      wb_bus_pkg::wb_adr_t adr;
      wb_bus_pkg::wb_dat_t wdat;
      wb_bus_pkg::wb_dat_t rdat;
      wb_bus_pkg::wb_sel_t sel;
      wb_bus_pkg::wb_cti_t cti;
      wb_bus_pkg::wb_bte_t bte;
      resp_t               resp;
      test_name = "ext";
      adr = 32'h4000_0000 | ($urandom & 32'h00ff_fffc);
      wdat = $urandom;
      sel = wb_bus_pkg::wb_sel_t'($urandom);
      cti = wb_bus_pkg::wb_cti_t'($urandom);
      bte = wb_bus_pkg::wb_bte_t'($urandom);
      ext_mode = resp_ack;
      ext_delay = 3;
      // Cycle type and burst extension only pass through
      @(negedge wb_clk);
      wbm1_cti_i = cti;
      wbm1_bte_i = bte;
      wbm0_cti_i = ~cti;
      wbm0_bte_i = ~bte;
      wb_write(1, adr, wdat, sel, resp);
      check_resp(resp_ack, resp);
      check_adr(adr, ext_last_adr);
      check_dat(wdat, ext_last_dat);
      check_ctl(sel, 1'b1, ext_last_sel, ext_last_we);
      check_burst(cti, bte, ext_last_cti, ext_last_bte);
      adr = adr ^ 32'h0000_0044;
      wb_read(0, adr, access_bound, rdat, resp);
      check_resp(resp_ack, resp);
      check_adr(adr, ext_last_adr);
      check_ctl(4'hf, 1'b0, ext_last_sel, ext_last_we);
      check_burst(~cti, ~bte, ext_last_cti, ext_last_bte);
      check_dat(ext_mem[adr[7:2]], rdat);
      ext_mode = resp_rty;
      wb_read(0, adr, access_bound, rdat, resp);
      check_resp(resp_rty, resp);
      ext_mode = resp_err;
      wb_read(1, adr, access_bound, rdat, resp);
      check_resp(resp_err, resp);
   endtask

   task automatic test_priority();
      wb_bus_pkg::wb_adr_t ext_adr;
      wb_bus_pkg::wb_dat_t d0;
      wb_bus_pkg::wb_dat_t d1;
      resp_t               r0;
      resp_t               r1;
      time                 t0;
      time                 t1;
      test_name = "priority";
      ext_adr = 32'h2000_0100;
      ext_mode = resp_ack;
      ext_delay = 20;
      fork
         begin
            wb_read(0, ext_adr, access_bound, d0, r0);
            t0 = $time;
         end
         begin
            // Debug port cuts in while the byte bus is still waiting
            repeat (4) @(negedge wb_clk);
            wb_read(1, wb_bus_pkg::wb_adr_t'(ram_idx[1] * 4), access_bound, d1, r1);
            t1 = $time;
         end
      join
      check_resp(resp_ack, r1);
      check_dat(ram_model[ram_idx[1]], d1);
      if (t0 <= t1)
         abort_run("Master 0 completed before the debug port released the bus");
      check_resp(resp_ack, r0);
      check_dat(ext_mem[ext_adr[7:2]], d0);
   endtask

   task automatic test_watchdog();
      wb_bus_pkg::wb_dat_t rdat;
      resp_t               resp;
      test_name = "watchdog";
      ext_mode = resp_none;
      ext_delay = 0;
      wb_read(0, 32'h3000_0000, wd_bound, rdat, resp);
      check_resp(resp_err, resp);
      wb_read(1, wb_bus_pkg::wb_adr_t'(ram_idx[0] * 4), access_bound, rdat, resp);
      check_resp(resp_ack, resp);
      check_dat(ram_model[ram_idx[0]], rdat);
   endtask

   initial begin : run_watchdog
      #(timeout_cycles * clk_period);
      abort_run("Timeout: the tests did not finish within their cycle budget");
   end

   initial begin : run_tests
      void'($urandom(32'h58696c19));
      for (int i = 0; i < 64; i++)
         ext_mem[i] = $urandom;
      drive_master(0, 1'b0, 1'b0, '0, '0, '0);
      drive_master(1, 1'b0, 1'b0, '0, '0, '0);
      wbm0_cti_i = '0;
      wbm0_bte_i = '0;
      wbm1_cti_i = '0;
      wbm1_bte_i = '0;
      wb_rst = 1'b1;
      repeat (reset_cycles) @(negedge wb_clk);
      wb_rst = 1'b0;
      test_ram();
      test_regs();
      test_ext();
      test_priority();
      test_watchdog();
      repeat (2) @(negedge wb_clk);
      if (errors == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         abort_run("Errors were recorded during the run");
      end
   end

endmodule

// File: verilog.f
hdl/wb_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/dbus_arbiter.sv
hdl/wb_ram.sv
hdl/wb_ctrl_regs.sv
hdl/dbus_top.sv
bench/dbus_arbiter_checker.sv
bench/dbus_tb.sv

// File: Makefile
# Verilator build and run of the data bus fabric testbench

TOP     = dbus_tb
OBJ_DIR = obj_dir

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

$(OBJ_DIR)/V$(TOP): verilog.f $(wildcard hdl/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) sim.log
